/* Bender.yml */
package:
  name: imuldiv_iterative

sources:
  # packages first, then the units, then the top level
  - source/imuldiv_pkg.sv
  - source/imuldiv_iter_pkg.sv
  - source/int_mul_iter_ctrl.sv
  - source/int_mul_iter_dpath.sv
  - source/int_mul_iterative.sv
  - source/int_div_iterative.sv
  - source/imuldiv_iterative.sv

  - target: test
    files:
      - testbench/imuldiv_chk.sv
      - testbench/tb_imuldiv.sv

/* source/imuldiv_iter_pkg.sv */
// ----------------------------
// step count and state encoding of the iterative mul and div units
// ----------------------------

package imuldiv_iter_pkg;

  // one shift step per operand bit
  localparam int unsigned num_iters = 32;

  // counter runs num_iters-1 down to 0
  localparam int unsigned count_width = 5;

  // idle -> calc (32 steps) -> sign (1 cycle) -> done (until taken)
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_sign = 2'd2,
    st_done = 2'd3
  } iter_state_e;

endpackage

/* source/imuldiv_iterative.sv */
// ----------------------------
// iterative mul/div unit, top level
// dispatches by function code, merges the two response streams
// ----------------------------
`timescale 1ns/1ps

module imuldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  input  imuldiv_fn_e             req_fn,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,
  output logic                    req_rdy,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output logic [result_width-1:0] resp_result
);

  logic                    mul_req_val;
  logic                    mul_req_rdy;
  logic                    mul_resp_val;
  logic [result_width-1:0] mul_resp_result;

  logic                    div_req_val;
  logic                    div_req_rdy;
  logic                    div_signed;
  logic                    div_resp_val;
  logic [result_width-1:0] div_resp_result;

  // ----------------------------
  // dispatch
  // ----------------------------

  // one op in flight, so both units must be idle to take a request
  assign req_rdy = mul_req_rdy && div_req_rdy;

  // gate by the shared rdy so an idle unit never starts beside a busy one
  assign mul_req_val = req_val && req_rdy && (req_fn == fn_mul);
  assign div_req_val = req_val && req_rdy && (req_fn != fn_mul);
  assign div_signed  = (req_fn == fn_div);

  int_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (mul_resp_result)
  );

  int_div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_signed  (div_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (div_req_rdy),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (div_resp_result)
  );

  // ----------------------------
  // merge, at most one valid at a time
  // ----------------------------

  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = mul_resp_val ? mul_resp_result : div_resp_result;

endmodule

/* source/imuldiv_pkg.sv */
// ----------------------------
// operand/result widths and function codes of the mul/div unit
// shared by the top level, the divider and the testbench
// ----------------------------

package imuldiv_pkg;

  // ----------------------------
  // widths
  // ----------------------------

  // operand width, fixed by the instruction set
  localparam int unsigned data_width = 32;

  // full product, or remainder in the upper half and quotient in the lower
  localparam int unsigned result_width = 2 * data_width;

  // ----------------------------
  // function codes
  // ----------------------------

  // rem and div share one code, the consumer picks its half
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

endpackage

/* source/int_div_iterative.sv */
// ----------------------------
// iterative restoring divider, signed or unsigned per request
// result is {remainder, quotient}
// ----------------------------
`timescale 1ns/1ps

module int_div_iterative
  import imuldiv_pkg::*;
  import imuldiv_iter_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  input  logic                    req_signed,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,
  output logic                    req_rdy,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output logic [result_width-1:0] resp_result
);

  iter_state_e            state;
  logic [count_width-1:0] counter;

  // quot starts as the dividend and fills with quotient bits from the right
  logic [data_width-1:0] quot;
  logic [data_width-1:0] rem;
  logic [data_width-1:0] divisor;
  logic [data_width-1:0] dividend;
  logic                  quot_neg;
  logic                  rem_neg;
  logic                  div_zero;

  logic                  accept;
  logic                  a_neg;
  logic                  b_neg;
  logic [data_width-1:0] a_mag;
  logic [data_width-1:0] b_mag;
  logic [data_width:0]   rem_shift;
  logic [data_width+1:0] diff;

  // ----------------------------
  // request decode
  // ----------------------------

  assign accept = req_val && req_rdy;

  // sign bits count only for signed division
  assign a_neg = req_signed && req_a[data_width-1];
  assign b_neg = req_signed && req_b[data_width-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ----------------------------
  // one restoring step
  // ----------------------------

  // next dividend bit shifted into the partial remainder
  assign rem_shift = {rem, quot[data_width-1]};
  // extra top bit is the borrow
  assign diff = {1'b0, rem_shift} - {2'b00, divisor};

  // ----------------------------
  // FSM and counter
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      counter <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_calc;
            counter <= count_width'(num_iters - 1);
          end
        end
        st_calc: begin
          counter <= counter - 1'b1;
          if (counter == '0) state <= st_sign;
        end
        st_sign: state <= st_done;
        st_done: if (resp_rdy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------
  // datapath registers
  // ----------------------------

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (accept) begin
          quot     <= a_mag;
          rem      <= '0;
          divisor  <= b_mag;
          dividend <= req_a;
          quot_neg <= a_neg ^ b_neg;
          rem_neg  <= a_neg;
          div_zero <= (req_b == '0);
        end
      end
      st_calc: begin
        // subtract only when it leaves the remainder non-negative
        if (!diff[data_width+1]) begin
          rem  <= diff[data_width-1:0];
          quot <= {quot[data_width-2:0], 1'b1};
        end else begin
          rem  <= rem_shift[data_width-1:0];
          quot <= {quot[data_width-2:0], 1'b0};
        end
      end
      st_sign: begin
        // divide by zero gives all ones and the dividend back
        if (div_zero) begin
          quot <= '1;
          rem  <= dividend;
        end else begin
          quot <= quot_neg ? (~quot + 1'b1) : quot;
          rem  <= rem_neg ? (~rem + 1'b1) : rem;
        end
      end
      default: begin
      end
    endcase
  end

  // ----------------------------
  // handshake and result
  // ----------------------------

  assign req_rdy     = (state == st_idle);
  assign resp_val    = (state == st_done);
  assign resp_result = {rem, quot};

endmodule

/* source/int_mul_iter_ctrl.sv */
// ----------------------------
// FSM of the iterative multiplier
// drives the datapath strobes and the val/rdy handshake
// ----------------------------
`timescale 1ns/1ps

module int_mul_iter_ctrl
  import imuldiv_iter_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en,
  output logic add_sel,
  output logic counter_load,
  output logic sign_fix,
  input  logic counter_is_zero,
  input  logic b_lsb
);

  iter_state_e state;

  // ----------------------------
  // state register
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req_val) state <= st_calc;
        // last step is the one taken with the counter at zero
        st_calc: if (counter_is_zero) state <= st_sign;
        st_sign: state <= st_done;
        st_done: if (resp_rdy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------
  // strobes, all low by default
  // ----------------------------

  always_comb begin
    req_rdy      = 1'b0;
    resp_val     = 1'b0;
    a_en         = 1'b0;
    a_mux_sel    = 1'b0;
    b_en         = 1'b0;
    b_mux_sel    = 1'b0;
    result_en    = 1'b0;
    add_sel      = 1'b0;
    counter_load = 1'b0;
    sign_fix     = 1'b0;
    case (state)
      st_idle: begin
        // rdy from state only, so accept is just req_val here
        req_rdy      = 1'b1;
        a_en         = req_val;
        b_en         = req_val;
        result_en    = req_val;
        counter_load = req_val;
      end
      st_calc: begin
        // shift both operands, add A when the current B bit is set
        a_en      = 1'b1;
        a_mux_sel = 1'b1;
        b_en      = 1'b1;
        b_mux_sel = 1'b1;
        result_en = 1'b1;
        add_sel   = b_lsb;
      end
      st_sign: begin
        result_en = 1'b1;
        sign_fix  = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/int_mul_iter_dpath.sv */
// ----------------------------
// datapath of the iterative multiplier
// sign-magnitude shift/add, steered by int_mul_iter_ctrl
// ----------------------------
`timescale 1ns/1ps

module int_mul_iter_dpath
  import imuldiv_pkg::*;
  import imuldiv_iter_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,
  input  logic                    a_en,
  input  logic                    a_mux_sel,
  input  logic                    b_en,
  input  logic                    b_mux_sel,
  input  logic                    result_en,
  input  logic                    add_sel,
  input  logic                    counter_load,
  input  logic                    sign_fix,
  output logic                    counter_is_zero,
  output logic                    b_lsb,
  output logic [result_width-1:0] resp_result
);

  logic [result_width-1:0] a_reg;
  logic [data_width-1:0]   b_reg;
  logic [result_width-1:0] result_reg;
  logic [count_width-1:0]  counter;
  logic                    sign_a;
  logic                    sign_b;

  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic [result_width-1:0] a_next;
  logic [data_width-1:0]   b_next;
  logic [result_width-1:0] result_next;

  // ----------------------------
  // operand muxes
  // ----------------------------

  // magnitudes of the incoming operands
  // 0x8000_0000 stays itself, which is the right unsigned magnitude
  assign a_mag = req_a[data_width-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[data_width-1] ? (~req_b + 1'b1) : req_b;

  // sel 0 loads the request, sel 1 takes the shifted value
  assign a_next = a_mux_sel ? (a_reg << 1) : {{data_width{1'b0}}, a_mag};
  assign b_next = b_mux_sel ? (b_reg >> 1) : b_mag;

  // load clears, sign_fix negates on mixed signs, else optional add
  always_comb begin
    if (counter_load) begin
      result_next = '0;
    end else if (sign_fix) begin
      result_next = (sign_a ^ sign_b) ? (~result_reg + 1'b1) : result_reg;
    end else if (add_sel) begin
      result_next = result_reg + a_reg;
    end else begin
      result_next = result_reg;
    end
  end

  // ----------------------------
  // registers
  // ----------------------------

  // step counter, decrements in every calc cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (counter_load) begin
      counter <= count_width'(num_iters - 1);
    end else if (b_en && b_mux_sel) begin
      counter <= counter - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) a_reg <= a_next;
    if (b_en) b_reg <= b_next;
    if (result_en) result_reg <= result_next;
    // signs are kept for the fix at the end
    if (counter_load) begin
      sign_a <= req_a[data_width-1];
      sign_b <= req_b[data_width-1];
    end
  end

  // status back to the FSM
  assign counter_is_zero = (counter == '0);
  assign b_lsb           = b_reg[0];
  assign resp_result     = result_reg;

endmodule

/* source/int_mul_iterative.sv */
// ----------------------------
// iterative signed multiplier, one val/rdy request and response port
// ----------------------------
`timescale 1ns/1ps

module int_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  logic [data_width-1:0]   req_a,
  input  logic [data_width-1:0]   req_b,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output logic [result_width-1:0] resp_result
);

  // strobes from control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic result_en;
  logic add_sel;
  logic counter_load;
  logic sign_fix;

  // status back to control
  logic counter_is_zero;
  logic b_lsb;

  int_mul_iter_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .add_sel         (add_sel),
    .counter_load    (counter_load),
    .sign_fix        (sign_fix),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb)
  );

  int_mul_iter_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .req_a           (req_a),
    .req_b           (req_b),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .add_sel         (add_sel),
    .counter_load    (counter_load),
    .sign_fix        (sign_fix),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .resp_result     (resp_result)
  );

endmodule

/* testbench/imuldiv_chk.sv */
// ----------------------------
// handshake and stability assertions, bound to imuldiv_iterative
// ----------------------------
`timescale 1ns/1ps

module imuldiv_chk
  import imuldiv_pkg::*;
(
  input logic                    clk,
  input logic                    reset,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic [result_width-1:0] resp_result
);

  // number of failed assertions, read by the testbench at the end of the run
  int fail_count = 0;

  // one op in flight, no new request while a response waits
  rdy_off_while_resp_a: assert property (
    @(posedge clk) disable iff (reset) resp_val |-> !req_rdy
  ) else begin
    $error("req_rdy high while resp_val is high");
    fail_count++;
  end

  // response stays offered until taken
  resp_val_hold_a: assert property (
    @(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> resp_val
  ) else begin
    $error("resp_val dropped before resp_rdy");
    fail_count++;
  end

  // data stays put under back-pressure
  resp_result_stable_a: assert property (
    @(posedge clk) disable iff (reset) (resp_val && !resp_rdy) |=> $stable(resp_result)
  ) else begin
    $error("resp_result changed while stalled");
    fail_count++;
  end

  // nothing offered right after reset
  resp_val_after_reset_a: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else begin
    $error("resp_val high in the cycle after reset");
    fail_count++;
  end

endmodule

bind imuldiv_iterative imuldiv_chk chk (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

/* testbench/tb_imuldiv.sv */
// ----------------------------
// testbench of the iterative mul/div unit
// runs a table of directed and random requests against a reference model
// ----------------------------
`timescale 1ns/1ps

module tb_imuldiv
  import imuldiv_pkg::*;
  import imuldiv_iter_pkg::*;
();

  // ----------------------------
  // constants
  // ----------------------------

  localparam int max_entries = 32;
  localparam int num_random = 13;
  // 32 calc edges, then the sign edge puts the unit in st_done
  localparam int resp_latency = num_iters + 1;
  // give up on one response well past the expected latency
  localparam int resp_wait_limit = 100;

  logic                    clk;
  logic                    reset;
  logic                    req_val;
  imuldiv_fn_e             req_fn;
  logic [data_width-1:0]   req_a;
  logic [data_width-1:0]   req_b;
  logic                    req_rdy;
  logic                    resp_val;
  logic                    resp_rdy;
  logic [result_width-1:0] resp_result;

  // stimulus table
  imuldiv_fn_e           tab_fn [max_entries];
  logic [data_width-1:0] tab_a [max_entries];
  logic [data_width-1:0] tab_b [max_entries];
  int                    tab_stall [max_entries];
  int                    num_entries;
  int                    max_stall;

  int     cycle_limit;
  int     cycle_count;
  int     passed;
  int     failed;
  integer seed;

  imuldiv_iterative UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // ----------------------------
  // reference model
  // ----------------------------

  // mul: signed 64-bit product
  // div: truncating quotient low, dividend-signed remainder high
  function automatic logic [result_width-1:0] model_result(
    input imuldiv_fn_e           fn,
    input logic [data_width-1:0] a,
    input logic [data_width-1:0] b
  );
    longint sa;
    longint sb;
    longint q;
    longint r;
    if (fn == fn_divu) begin
      sa = {{data_width{1'b0}}, a};
      sb = {{data_width{1'b0}}, b};
    end else begin
      sa = {{data_width{a[data_width-1]}}, a};
      sb = {{data_width{b[data_width-1]}}, b};
    end
    if (fn == fn_mul) return sa * sb;
    // zero divisor: all-ones quotient, dividend as remainder
    if (b == '0) return {a, {data_width{1'b1}}};
    q = sa / sb;
    r = sa % sb;
    return {r[data_width-1:0], q[data_width-1:0]};
  endfunction

  function automatic string fn_name(input imuldiv_fn_e fn);
    case (fn)
      fn_mul:  return "mul ";
      fn_div:  return "div ";
      fn_divu: return "divu";
      default: return "????";
    endcase
  endfunction

  // ----------------------------
  // table
  // ----------------------------

  task automatic add_entry(
    input imuldiv_fn_e           fn,
    input logic [data_width-1:0] a,
    input logic [data_width-1:0] b,
    input int                    stall
  );
    tab_fn[num_entries]    = fn;
    tab_a[num_entries]     = a;
    tab_b[num_entries]     = b;
    tab_stall[num_entries] = stall;
    num_entries++;
  endtask

  task automatic load_table();
    logic [data_width-1:0] rnd;
    imuldiv_fn_e           fn;
    // multiply: zero, one, minus one, extremes, mixed signs
    add_entry(fn_mul, 32'h0000_0000, 32'h0000_1234, 0);
    add_entry(fn_mul, 32'h0000_0001, 32'hdead_beef, 1);
    add_entry(fn_mul, 32'hffff_ffff, 32'hffff_ffff, 0);
    add_entry(fn_mul, 32'h7fff_ffff, 32'h7fff_ffff, 2);
    add_entry(fn_mul, 32'h8000_0000, 32'h8000_0000, 0);
    add_entry(fn_mul, 32'h8000_0000, 32'h7fff_ffff, 1);
    add_entry(fn_mul, 32'hffff_fff9, 32'h0000_000d, 3);
    add_entry(fn_mul, 32'h8000_0000, 32'hffff_ffff, 0);
    // signed divide, all sign combinations and the overflow case
    add_entry(fn_div, 32'd100, 32'd7, 0);
    add_entry(fn_div, 32'hffff_ff9c, 32'd7, 2);
    add_entry(fn_div, 32'd100, 32'hffff_fff9, 0);
    add_entry(fn_div, 32'hffff_ff9c, 32'hffff_fff9, 1);
    add_entry(fn_div, 32'h8000_0000, 32'hffff_ffff, 0);
    // unsigned divide with the top bit set
    add_entry(fn_divu, 32'hffff_fff0, 32'h0000_0010, 0);
    add_entry(fn_divu, 32'hffff_ffff, 32'hffff_fffe, 3);
    // zero divisor under both codes
    add_entry(fn_div, 32'h1234_5678, 32'h0000_0000, 2);
    add_entry(fn_divu, 32'hfedc_ba98, 32'h0000_0000, 0);
    // random tail
    for (int i = 0; i < num_random; i++) begin
      rnd = $random(seed);
      case (rnd % 3)
        0:       fn = fn_mul;
        1:       fn = fn_div;
        default: fn = fn_divu;
      endcase
      rnd = $random(seed);
      add_entry(fn, $random(seed), $random(seed), rnd % 4);
    end
  endtask

  // ----------------------------
  // one request/response round
  // ----------------------------

  task automatic run_entry(input int idx);
    logic [result_width-1:0] expected;
    logic [result_width-1:0] held;
    int                      edges;
    int                      bad;
    bad      = 0;
    edges    = 0;
    expected = model_result(tab_fn[idx], tab_a[idx], tab_b[idx]);
    held     = '0;
    @(posedge clk);
    req_val <= 1'b1;
    req_fn  <= tab_fn[idx];
    req_a   <= tab_a[idx];
    req_b   <= tab_b[idx];
    @(negedge clk);
    if (req_rdy !== 1'b1) begin
      $display("request %0d found the unit busy when it should be idle", idx);
      bad++;
    end
    // accepting edge
    @(posedge clk);
    req_val <= 1'b0;
    @(negedge clk);
    if (req_rdy !== 1'b0) begin
      $display("error: req_rdy = %h, expected %h", req_rdy, 1'b0);
      bad++;
    end
    // count edges past accept until resp_val shows up
    while (resp_val !== 1'b1 && edges < resp_wait_limit) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (resp_val !== 1'b1) begin
      $display("request %0d got no response within %0d cycles", idx, resp_wait_limit);
      bad++;
    end else begin
      if (edges != resp_latency) begin
        $display("error: resp_val latency = %h, expected %h", edges, resp_latency);
        bad++;
      end
      if (resp_result !== expected) begin
        $display("error: resp_result = %h, expected %h", resp_result, expected);
        bad++;
      end
      held = resp_result;
      // back-pressure, response must hold
      repeat (tab_stall[idx]) begin
        @(posedge clk);
        @(negedge clk);
        if (resp_val !== 1'b1) begin
          $display("error: resp_val = %h, expected %h", resp_val, 1'b1);
          bad++;
        end
        if (resp_result !== held) begin
          $display("error: resp_result = %h, expected %h", resp_result, held);
          bad++;
        end
        if (req_rdy !== 1'b0) begin
          $display("error: req_rdy = %h, expected %h", req_rdy, 1'b0);
          bad++;
        end
      end
      @(posedge clk);
      resp_rdy <= 1'b1;
      // transfer edge
      @(posedge clk);
      resp_rdy <= 1'b0;
      @(negedge clk);
      if (resp_val !== 1'b0) begin
        $display("error: resp_val = %h, expected %h", resp_val, 1'b0);
        bad++;
      end
      if (req_rdy !== 1'b1) begin
        $display("error: req_rdy = %h, expected %h", req_rdy, 1'b1);
        bad++;
      end
    end
    if (bad == 0) passed++;
    else failed++;
    $display("test %0d %s a=%h b=%h stall=%0d result=%h %s", idx, fn_name(tab_fn[idx]),
             tab_a[idx], tab_b[idx], tab_stall[idx], held, (bad == 0) ? "ok" : "FAILED");
  endtask

  // ----------------------------
  // clock, timeout, main sequence
  // ----------------------------

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // limit is set once the table is known
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run still going after %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    req_val     = 1'b0;
    req_fn      = fn_mul;
    req_a       = '0;
    req_b       = '0;
    resp_rdy    = 1'b0;
    passed      = 0;
    failed      = 0;
    num_entries = 0;
    max_stall   = 0;
    seed        = 32'h15e7;
    load_table();
    for (int i = 0; i < num_entries; i++) begin
      if (tab_stall[i] > max_stall) max_stall = tab_stall[i];
    end
    // per entry: latency, stall, and a few handshake cycles
    cycle_limit = num_entries * (resp_latency + 1 + max_stall + 4) + 50;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < num_entries; i++) begin
      run_entry(i);
    end
    $display("done: %0d tests, %0d passed, %0d failed, %0d assertion failures",
             num_entries, passed, failed, UUT.chk.fail_count);
    if (failed == 0 && UUT.chk.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* vlog.f */
source/imuldiv_pkg.sv
source/imuldiv_iter_pkg.sv
source/int_mul_iter_ctrl.sv
source/int_mul_iter_dpath.sv
source/int_mul_iterative.sv
source/int_div_iterative.sv
source/imuldiv_iterative.sv
testbench/imuldiv_chk.sv
testbench/tb_imuldiv.sv
